/* spi_master.f */
spi_pkg.sv
spi_cmd_decode.sv
spi_shift_engine.sv
spi_read_capture.sv
spi_master_top.sv
spi_slave_model.sv
tb_spi_master_top.sv

/* tb_spi_master_top.sv */
`timescale 1ns/1ps

module tb_spi_master_top;

  localparam int CMD_WIDTH  = 12;
  localparam int READ_WIDTH = 8;
  localparam int CLK_DIV    = 2;
  localparam int TIMEOUT    = 400;  // clk cycles per wait

  logic                  clk;
  logic                  rst_n;
  logic [CMD_WIDTH-1:0]  cmd_in;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  logic                  sclk;
  logic                  cs;
  logic                  mosi;
  logic                  miso;
  logic                  read_vld;
  logic [READ_WIDTH-1:0] read_data;
  logic [CMD_WIDTH-1:0]  slave_word;
  int                    slave_pulses;
  int                    slave_frames;

  int                    mismatches = 0;
  int                    timeouts = 0;
  int                    vld_cnt = 0;
  int                    low_run = 0;
  int                    last_low = 0;
  logic [READ_WIDTH-1:0] read_seen;
  logic [READ_WIDTH-1:0] sb [8];  // expected slave registers

  spi_master_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_rdy   (cmd_rdy),
    .cmd_vld   (cmd_vld),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model slave (
    .rst_n     (rst_n),
    .cs        (cs),
    .sclk      (sclk),
    .mosi      (mosi),
    .miso      (miso),
    .last_word (slave_word),
    .pulse_cnt (slave_pulses),
    .frame_cnt (slave_frames)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------
  // monitors
  // ----------------------------------------
  always @(negedge clk)
  begin
    if (read_vld)
    begin
      vld_cnt   = vld_cnt + 1;
      read_seen = read_data;
    end
  end

  always @(negedge clk)
  begin
    if (rst_n && cs)
      check_value("sclk", sclk, 0);  // idle low outside frames
    if (!cs)
      low_run = low_run + 1;
    else if (low_run != 0)
    begin
      last_low = low_run;
      low_run  = 0;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else
    begin
      mismatches++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  function automatic logic [CMD_WIDTH-1:0] make_cmd(input logic wr, input logic [2:0] addr,
                                                    input logic [7:0] data);
    return {wr, addr, wr ? data : 8'h00};
  endfunction

  // ----------------------------------------
  // host side driving at negedge
  // ----------------------------------------
  task automatic send_cmd(input logic [CMD_WIDTH-1:0] cmd);
    int n;
    begin
      n       = 0;
      cmd_in  = cmd;
      cmd_vld = 1'b1;
      while (!cmd_rdy && n < TIMEOUT)
      begin
        @(negedge clk);
        n++;
      end
      assert (cmd_rdy) else
      begin
        timeouts++;
        $display("timeout waiting for cmd_rdy to accept command %h", cmd);
      end
      @(negedge clk);  // handshake edge passed
      cmd_vld = 1'b0;
    end
  endtask

  task automatic wait_frame_end();
    int n;
    begin
      n = 0;
      while (!(cmd_rdy && cs) && n < TIMEOUT)
      begin
        @(negedge clk);
        n++;
      end
      assert (cmd_rdy && cs) else
      begin
        timeouts++;
        $display("timeout waiting for the frame to end and cmd_rdy to return");
      end
    end
  endtask

  task automatic run_frame(input logic [CMD_WIDTH-1:0] cmd);
    send_cmd(cmd);
    wait_frame_end();
  endtask

  task automatic write_reg(input logic [2:0] addr, input logic [7:0] data);
    run_frame(make_cmd(1'b1, addr, data));
    sb[addr] = data;
    check_value("slave reg", slave.regs[addr], data);
  endtask

  task automatic read_reg(input logic [2:0] addr);
    int vld0;
    begin
      vld0 = vld_cnt;
      run_frame(make_cmd(1'b0, addr, 8'h00));
      check_value("read_vld pulses", vld_cnt - vld0, 1);
      check_value("read_data", read_seen, sb[addr]);
      check_value("read_data held", read_data, sb[addr]);
      check_value("sclk pulses", slave_pulses, CMD_WIDTH);
    end
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic reset_state();
    repeat (10)
    begin
      @(negedge clk);
      check_value("cs", cs, 1);
      check_value("sclk", sclk, 0);
      check_value("read_vld", read_vld, 0);
      check_value("cmd_rdy", cmd_rdy, 1);
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_value("cs", cs, 1);
    check_value("sclk", sclk, 0);
    check_value("read_vld", read_vld, 0);
    check_value("cmd_rdy", cmd_rdy, 1);
  endtask

  task automatic single_write(input logic [2:0] addr, input logic [7:0] data);
    int frames0;
    int vld0;
    begin
      frames0 = slave_frames;
      vld0    = vld_cnt;
      write_reg(addr, data);
      check_value("sclk pulses", slave_pulses, CMD_WIDTH);
      check_value("slave word", slave_word, make_cmd(1'b1, addr, data));
      check_value("read_vld pulses", vld_cnt - vld0, 0);
      check_value("slave frames", slave_frames, frames0 + 1);
      check_value("cs low cycles", last_low, (2 * CMD_WIDTH + 2) * CLK_DIV);
    end
  endtask

  task automatic write_then_read(input logic [2:0] addr, input logic [7:0] data);
    write_reg(addr, data);
    read_reg(addr);
  endtask

  task automatic back_pressure();
    int f0;
    begin
      f0 = slave_frames;
      send_cmd(make_cmd(1'b1, 3'd1, 8'h3c));
      check_value("cmd_rdy", cmd_rdy, 0);
      send_cmd(make_cmd(1'b1, 3'd6, 8'hc3));  // waits for the first frame
      check_value("slave frames", slave_frames, f0 + 1);
      wait_frame_end();
      repeat (20) @(negedge clk);
      check_value("slave frames", slave_frames, f0 + 2);
      check_value("cs", cs, 1);
      sb[1] = 8'h3c;
      sb[6] = 8'hc3;
      check_value("slave reg 1", slave.regs[1], sb[1]);
      check_value("slave reg 6", slave.regs[6], sb[6]);
    end
  endtask

  task automatic random_sequence(input int count);
    logic [2:0] addr;
    logic [7:0] data;
    begin
      for (int i = 0; i < count; i++)
      begin
        addr = 3'($urandom % 8);
        data = 8'($urandom);
        if ($urandom % 2)
          write_reg(addr, data);
        else
          read_reg(addr);
      end
    end
  endtask

  initial
  begin
    void'($urandom(32'he9873b5c));
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    foreach (sb[i])
      sb[i] = '0;
    reset_state();
    single_write(3'd2, 8'h5c);
    write_then_read(3'd5, 8'ha7);
    back_pressure();
    random_sequence(40);
    $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* spi_slave_model.sv */
`timescale 1ns/1ps

module spi_slave_model #(
  parameter int CMD_WIDTH  = 12,
  parameter int READ_WIDTH = 8
) (
  input  logic                 rst_n,
  input  logic                 cs,
  input  logic                 sclk,
  input  logic                 mosi,
  output logic                 miso,
  output logic [CMD_WIDTH-1:0] last_word,
  output int                   pulse_cnt,
  output int                   frame_cnt
);

  localparam int HDR_W  = CMD_WIDTH - READ_WIDTH;
  localparam int ADDR_W = HDR_W - 1;

  logic [READ_WIDTH-1:0] regs [2**ADDR_W];
  logic [CMD_WIDTH-1:0]  rx_shift;
  logic [READ_WIDTH-1:0] tx_shift;
  logic                  rd_frame = 1'b0;
  int                    cnt = 0;

  // ----------------------------------------
  // receive side, rising sclk and frame end
  // ----------------------------------------
  always @(posedge sclk or posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      foreach (regs[i])
        regs[i] = '0;
      rx_shift  = '0;
      last_word = '0;
      cnt       = 0;
      pulse_cnt = 0;
      frame_cnt = 0;
    end
    else if (cs)
    begin
      frame_cnt = frame_cnt + 1;
      pulse_cnt = cnt;
      last_word = rx_shift;
      if (rx_shift[CMD_WIDTH-1] && cnt == CMD_WIDTH)
        regs[rx_shift[CMD_WIDTH-2 -: ADDR_W]] = rx_shift[READ_WIDTH-1:0];  // write lands at cs rise
      cnt      = 0;
      rx_shift = '0;
    end
    else
    begin
      rx_shift = {rx_shift[CMD_WIDTH-2:0], mosi};
      cnt      = cnt + 1;
    end
  end

  // read data out on falling sclk, msb first
  always @(negedge sclk)
  begin
    if (!cs && cnt == HDR_W)
    begin
      rd_frame = !rx_shift[HDR_W-1];
      tx_shift = regs[rx_shift[ADDR_W-1:0]];
    end
    if (!cs && rd_frame && cnt >= HDR_W && cnt < CMD_WIDTH)
    begin
      miso     = tx_shift[READ_WIDTH-1];
      tx_shift = tx_shift << 1;
    end
    else
      miso = 1'b0;
  end

endmodule

/* spi_master_top.sv */
`timescale 1ns/1ps

module spi_master_top
  import spi_pkg::*;
#(
  parameter int CMD_WIDTH  = 12,
  parameter int READ_WIDTH = 8,
  parameter int CLK_DIV    = 2
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [CMD_WIDTH-1:0]  cmd_in,
  output logic                  cmd_rdy,
  input  logic                  cmd_vld,
  output logic                  sclk,
  output logic                  cs,
  output logic                  mosi,
  input  logic                  miso,
  output logic                  read_vld,
  output logic [READ_WIDTH-1:0] read_data
);

  localparam int BIT_W = $clog2(CMD_WIDTH + 1);

  // ----------------------------------------
  // decode to engine
  // ----------------------------------------
  logic                 start;
  spi_op_e              op;
  logic [CMD_WIDTH-1:0] tx_word;
  logic [BIT_W-1:0]     tx_bits;
  logic                 frame_done;

  // engine to capture
  logic                 sample;
  logic                 sample_bit;
  logic                 frame_start;

  spi_cmd_decode #(
    .CMD_WIDTH  (CMD_WIDTH),
    .READ_WIDTH (READ_WIDTH)
  ) u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .frame_done (frame_done),
    .cmd_rdy    (cmd_rdy),
    .start      (start),
    .op         (op),
    .tx_word    (tx_word),
    .tx_bits    (tx_bits)
  );

  spi_shift_engine #(
    .CMD_WIDTH  (CMD_WIDTH),
    .READ_WIDTH (READ_WIDTH),
    .CLK_DIV    (CLK_DIV)
  ) u_engine (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .op          (op),
    .tx_word     (tx_word),
    .tx_bits     (tx_bits),
    .miso        (miso),
    .cs          (cs),
    .sclk        (sclk),
    .mosi        (mosi),
    .sample      (sample),
    .sample_bit  (sample_bit),
    .frame_start (frame_start),
    .frame_done  (frame_done)
  );

  spi_read_capture #(
    .READ_WIDTH (READ_WIDTH)
  ) u_capture (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_start (frame_start),
    .sample      (sample),
    .sample_bit  (sample_bit),
    .read_data   (read_data),
    .read_vld    (read_vld)
  );

endmodule

/* spi_read_capture.sv */
`timescale 1ns/1ps

module spi_read_capture #(
  parameter int READ_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  frame_start,
  input  logic                  sample,
  input  logic                  sample_bit,
  output logic [READ_WIDTH-1:0] read_data,
  output logic                  read_vld
);

  localparam int CNT_W = $clog2(READ_WIDTH + 1);

  logic [CNT_W-1:0]      bit_cnt;
  logic [READ_WIDTH-1:0] shift_q;
  logic [READ_WIDTH-1:0] shift_nxt;
  logic                  last_bit;

  assign shift_nxt = {shift_q[READ_WIDTH-2:0], sample_bit};  // msb first
  assign last_bit  = (bit_cnt == CNT_W'(READ_WIDTH - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt  <= '0;
      read_vld <= 1'b0;
    end
    else
    begin
      read_vld <= 1'b0;
      if (frame_start)
        bit_cnt <= '0;
      else if (sample)
      begin
        if (last_bit)
        begin
          bit_cnt  <= '0;
          read_vld <= 1'b1;
        end
        else
          bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // read_data only moves when a full word is in
  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      shift_q <= shift_nxt;
      if (last_bit)
        read_data <= shift_nxt;
    end
  end

endmodule

/* spi_shift_engine.sv */
`timescale 1ns/1ps

module spi_shift_engine
  import spi_pkg::*;
#(
  parameter int CMD_WIDTH  = 12,
  parameter int READ_WIDTH = 8,
  parameter int CLK_DIV    = 2,
  localparam int BIT_W     = $clog2(CMD_WIDTH + 1)
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  spi_op_e              op,
  input  logic [CMD_WIDTH-1:0] tx_word,
  input  logic [BIT_W-1:0]     tx_bits,
  input  logic                 miso,
  output logic                 cs,
  output logic                 sclk,
  output logic                 mosi,
  output logic                 sample,
  output logic                 sample_bit,
  output logic                 frame_start,
  output logic                 frame_done
);

  localparam int DIV_W = $clog2(2 * CLK_DIV);

  spi_state_e           state;
  logic [DIV_W-1:0]     div_cnt;
  logic [BIT_W-1:0]     bit_cnt;
  logic [CMD_WIDTH-1:0] tx_shift;
  logic                 half_end;
  logic                 bit_end;
  logic                 last_tx;
  logic                 last_rx;

  assign half_end = (div_cnt == DIV_W'(CLK_DIV - 1));      // sclk rises here
  assign bit_end  = (div_cnt == DIV_W'(2 * CLK_DIV - 1));  // sclk falls here
  assign last_tx  = (bit_cnt == tx_bits - 1'b1);
  assign last_rx  = (bit_cnt == BIT_W'(READ_WIDTH - 1));

  // ----------------------------------------
  // frame FSM
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state       <= st_idle;
      div_cnt     <= '0;
      bit_cnt     <= '0;
      cs          <= 1'b1;
      sclk        <= 1'b0;
      mosi        <= 1'b0;
      sample      <= 1'b0;
      frame_start <= 1'b0;
      frame_done  <= 1'b0;
    end
    else
    begin
      sample      <= 1'b0;
      frame_start <= 1'b0;
      frame_done  <= 1'b0;
      case (state)
        st_idle:
        begin
          if (start)
          begin
            state       <= st_setup;
            cs          <= 1'b0;
            mosi        <= tx_word[CMD_WIDTH-1];
            div_cnt     <= '0;
            bit_cnt     <= '0;
            frame_start <= (op == op_read);
          end
        end
        st_setup:
        begin
          if (half_end)
          begin
            state   <= st_shift;
            div_cnt <= '0;
          end
          else
            div_cnt <= div_cnt + 1'b1;
        end
        st_shift:
        begin
          if (half_end)
            sclk <= 1'b1;
          if (bit_end)
          begin
            sclk    <= 1'b0;
            div_cnt <= '0;
            if (last_tx)
            begin
              bit_cnt <= '0;
              mosi    <= 1'b0;
              state   <= (op == op_write) ? st_hold : st_read;
            end
            else
            begin
              bit_cnt <= bit_cnt + 1'b1;
              mosi    <= tx_shift[CMD_WIDTH-1];  // next bit on falling sclk
            end
          end
          else
            div_cnt <= div_cnt + 1'b1;
        end
        st_read:
        begin
          if (half_end)
          begin
            sclk   <= 1'b1;
            sample <= 1'b1;
          end
          if (bit_end)
          begin
            sclk    <= 1'b0;
            div_cnt <= '0;
            if (last_rx)
              state <= st_hold;
            else
              bit_cnt <= bit_cnt + 1'b1;
          end
          else
            div_cnt <= div_cnt + 1'b1;
        end
        st_hold:
        begin
          if (half_end)
          begin
            state      <= st_idle;
            div_cnt    <= '0;
            cs         <= 1'b1;
            frame_done <= 1'b1;
          end
          else
            div_cnt <= div_cnt + 1'b1;
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  // data path, first bit already on mosi at load
  always_ff @(posedge clk)
  begin
    if (state == st_idle && start)
      tx_shift <= {tx_word[CMD_WIDTH-2:0], 1'b0};
    else if (state == st_shift && bit_end)
      tx_shift <= {tx_shift[CMD_WIDTH-2:0], 1'b0};
    if (state == st_read && half_end)
      sample_bit <= miso;  // miso stable since last falling sclk
  end

endmodule

/* spi_cmd_decode.sv */
`timescale 1ns/1ps

module spi_cmd_decode
  import spi_pkg::*;
#(
  parameter int CMD_WIDTH  = 12,
  parameter int READ_WIDTH = 8,
  localparam int BIT_W     = $clog2(CMD_WIDTH + 1)
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [CMD_WIDTH-1:0] cmd_in,
  input  logic                 cmd_vld,
  input  logic                 frame_done,
  output logic                 cmd_rdy,
  output logic                 start,
  output spi_op_e              op,
  output logic [CMD_WIDTH-1:0] tx_word,
  output logic [BIT_W-1:0]     tx_bits
);

  logic    accept;
  logic    pending;  // command latched, start goes out next
  spi_op_e cmd_op;

  assign accept = cmd_vld && cmd_rdy;
  assign cmd_op = spi_op_e'(cmd_in[CMD_WIDTH-1]);

  // ----------------------------------------
  // handshake and start pulse
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cmd_rdy <= 1'b1;
      pending <= 1'b0;
      start   <= 1'b0;
    end
    else
    begin
      pending <= accept;
      start   <= pending;
      if (accept)
        cmd_rdy <= 1'b0;
      else if (frame_done)
        cmd_rdy <= 1'b1;  // free again once cs is back up
    end
  end

  // frame description, held for the whole frame
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      tx_word <= cmd_in;
      op      <= cmd_op;
      if (cmd_op == op_write)
        tx_bits <= BIT_W'(CMD_WIDTH);
      else
        tx_bits <= BIT_W'(CMD_WIDTH - READ_WIDTH);  // header only
    end
  end

endmodule

/* spi_pkg.sv */
package spi_pkg;

  // ----------------------------------------
  // command operation, top bit of cmd_in
  // ----------------------------------------
  typedef enum logic
  {
    op_read  = 1'b0,
    op_write = 1'b1
  } spi_op_e;

  // ----------------------------------------
  // shift engine states
  // ----------------------------------------
  typedef enum logic [2:0]
  {
    st_idle,   // cs high, waiting for start
    st_setup,  // cs low, first bit on mosi
    st_shift,  // header or full command out
    st_read,   // read bits in from miso
    st_hold    // sclk low before cs rises
  } spi_state_e;

endpackage
